// ==== dv/id_top_tb.sv ====
/*
  Testbench for the decode stage. Builds RV32I and RVC words from random
  fields, keeps the expected scoreboard entries in a queue and checks each
  acked entry and the handshake rules with concurrent assertions.
*/
module id_top_tb
  import riscv_pkg::*;
  import decode_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_TESTS = 6;
  localparam int CYCLES_PER_TEST = 400;

  typedef struct packed {
    scoreboard_entry_t e;
    logic [31:0]       w;
    logic              c;
  } exp_t;

  logic clk_i = 1'b0;
  logic rst_ni = 1'b0;
  logic flush_i = 1'b0;
  logic fetch_valid_i = 1'b0;
  logic [31:0] fetch_instr_i = '0;
  logic [31:0] fetch_pc_i = '0;
  logic fetch_fault_i = 1'b0;
  logic issue_ack_i = 1'b0;
  logic fetch_ready_o;
  logic issue_valid_o;
  scoreboard_entry_t issue_entry_o;
  logic [31:0] issue_orig_instr_o;
  logic issue_is_ctrl_flow_o;

  // Stimulus state
  logic [15:0] stim_lfsr = 16'd6228;
  logic [15:0] ack_lfsr = 16'd6228;
  logic ack_rand = 1'b0;
  logic ack_hold = 1'b0;
  logic rand_gap = 1'b0;
  logic reset_bad = 1'b0;
  logic [31:0] pc = 32'h8000_0000;
  logic [31:0] word;
  scoreboard_entry_t nx;
  int errors = 0;
  int accept_cnt = 0;
  int test_num = 0;

  // Expected queue and its head
  exp_t exp_q[$];
  exp_t exp_head = '0;
  logic exp_any = 1'b0;

  op_t alu_by_f3 [8] = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};
  logic [2:0] load_f3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
  op_t load_op [5] = '{LB, LH, LW, LBU, LHU};
  op_t store_op [3] = '{SB, SH, SW};
  logic [2:0] br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
  op_t br_op [6] = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};

  id_top u_dut (.*);

  always #10 clk_i = ~clk_i;

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rbits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      stim_lfsr = lfsr_next(stim_lfsr);
      r = {r[30:0], stim_lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] sext(input logic [31:0] v, input int w);
    return 32'($signed(v << (32 - w)) >>> (32 - w));
  endfunction

  function automatic scoreboard_entry_t blank(input logic [31:0] p, input logic comp);
    scoreboard_entry_t e;
    e = '0;
    e.pc = p;
    e.is_compressed = comp;
    return e;
  endfunction

  // Drive one word until fetch takes it
  task automatic send(input logic fault);
    int seen;
    int gap;
    gap = rand_gap ? int'(rbits(2)) : 0;
    repeat (gap) @(negedge clk_i);
    seen = accept_cnt;
    fetch_valid_i = 1'b1;
    fetch_instr_i = word;
    fetch_pc_i = pc;
    fetch_fault_i = fault;
    do @(negedge clk_i); while (accept_cnt == seen);
    fetch_valid_i = 1'b0;
    fetch_fault_i = 1'b0;
    pc = pc + 32'd4;
  endtask

  task automatic gen_alu();
    logic [2:0] f3;
    logic alt;
    logic [4:0] rs1, rs2, rd;
    logic [11:0] imm;
    f3 = 3'(rbits(3));
    alt = 1'(rbits(1));
    rs1 = 5'(rbits(5));
    rs2 = 5'(rbits(5));
    rd = 5'(rbits(5));
    imm = 12'(rbits(12));
    nx = blank(pc, 1'b0);
    nx.fu = FU_ALU;
    nx.op = alu_by_f3[f3];
    nx.rs1 = rs1;
    nx.rd = rd;
    if (rbits(1) == 1) begin
      // Only ADD and SRL have an alternate form
      if (f3 != 3'd0 && f3 != 3'd5) alt = 1'b0;
      if (alt) nx.op = (f3 == 3'd0) ? SUB : SRA;
      nx.rs2 = rs2;
      word = {alt ? 7'b0100000 : 7'b0, rs2, rs1, f3, rd, OPCODE_OP};
    end else begin
      if (f3 == 3'd1) imm[11:5] = '0;
      if (f3 == 3'd5) begin
        imm[11:5] = alt ? 7'b0100000 : 7'b0;
        if (alt) nx.op = SRA;
      end
      nx.imm = sext(32'(imm), 12);
      nx.use_imm = 1'b1;
      word = {imm, rs1, f3, rd, OPCODE_OPIMM};
    end
    send(1'b0);
  endtask

  task automatic gen_other();
    int k;
    int s;
    logic [4:0] rs1, rs2, rd;
    logic [11:0] i12;
    logic [12:0] b;
    logic [20:0] j;
    logic [19:0] u;
    k = int'(rbits(4)) % 7;
    rs1 = 5'(rbits(5));
    rs2 = 5'(rbits(5));
    rd = 5'(rbits(5));
    i12 = 12'(rbits(12));
    b = {12'(rbits(12)), 1'b0};
    j = {20'(rbits(20)), 1'b0};
    u = 20'(rbits(20));
    nx = blank(pc, 1'b0);
    nx.use_imm = 1'b1;
    case (k)
      0: begin
        s = int'(rbits(3)) % 5;
        nx.fu = FU_LOAD;
        nx.op = load_op[s];
        nx.rs1 = rs1;
        nx.rd = rd;
        nx.imm = sext(32'(i12), 12);
        word = {i12, rs1, load_f3[s], rd, OPCODE_LOAD};
      end
      1: begin
        s = int'(rbits(2)) % 3;
        nx.fu = FU_STORE;
        nx.op = store_op[s];
        nx.rs1 = rs1;
        nx.rs2 = rs2;
        nx.imm = sext(32'(i12), 12);
        word = {i12[11:5], rs2, rs1, 3'(s), i12[4:0], OPCODE_STORE};
      end
      2: begin
        s = int'(rbits(3)) % 6;
        nx.fu = FU_CTRL;
        nx.op = br_op[s];
        nx.rs1 = rs1;
        nx.rs2 = rs2;
        nx.imm = sext(32'(b), 13);
        nx.use_imm = 1'b0;
        word = {b[12], b[10:5], rs2, rs1, br_f3[s], b[4:1], b[11], OPCODE_BRANCH};
      end
      3: begin
        nx.fu = FU_CTRL;
        nx.op = JAL;
        nx.rd = rd;
        nx.imm = sext(32'(j), 21);
        nx.use_pc = 1'b1;
        word = {j[20], j[10:1], j[11], j[19:12], rd, OPCODE_JAL};
      end
      4: begin
        nx.fu = FU_CTRL;
        nx.op = JALR;
        nx.rs1 = rs1;
        nx.rd = rd;
        nx.imm = sext(32'(i12), 12);
        word = {i12, rs1, 3'b000, rd, OPCODE_JALR};
      end
      default: begin
        nx.fu = FU_ALU;
        nx.op = (k == 5) ? LUI : AUIPC;
        nx.rd = rd;
        nx.imm = {u, 12'b0};
        nx.use_pc = (k == 6);
        word = {u, rd, (k == 5) ? OPCODE_LUI : OPCODE_AUIPC};
      end
    endcase
    send(1'b0);
  endtask

  task automatic gen_compressed();
    int k;
    logic [15:0] h;
    logic [5:0] i6;
    logic [4:0] r, r2;
    logic [2:0] p, q;
    logic [6:0] u;
    logic [11:0] j;
    logic [8:0] b;
    logic t;
    k = int'(rbits(4)) % 10;
    i6 = 6'(rbits(6));
    r = 5'(rbits(5));
    r2 = 5'(rbits(5));
    p = 3'(rbits(3));
    q = 3'(rbits(3));
    u = {5'(rbits(5)), 2'b00};
    j = {11'(rbits(11)), 1'b0};
    b = {8'(rbits(8)), 1'b0};
    t = 1'(rbits(1));
    nx = blank(pc, 1'b1);
    nx.fu = FU_ALU;
    nx.op = ADD;
    nx.use_imm = 1'b1;
    nx.imm = sext(32'(i6), 6);
    case (k)
      0: begin
        h = {3'b000, i6[5], r, i6[4:0], 2'b01};
        nx.rs1 = r;
        nx.rd = r;
      end
      1: begin
        h = 16'h0001;
        nx.imm = '0;
      end
      2: begin
        h = {3'b010, i6[5], r, i6[4:0], 2'b01};
        nx.rd = r;
      end
      3: begin
        // rd of x0 and x2 and a zero immediate are not C.LUI
        if (r < 5'd3) r = r + 5'd3;
        if (i6 == 6'd0) i6 = 6'd1;
        h = {3'b011, i6[5], r, i6[4:0], 2'b01};
        nx.op = LUI;
        nx.rd = r;
        nx.imm = sext(32'({i6, 12'b0}), 18);
      end
      4, 5: begin
        if (r2 == 5'd0) r2 = 5'd1;
        h = {3'b100, (k == 5), r, r2, 2'b10};
        nx.rs1 = (k == 5) ? r : 5'd0;
        nx.rs2 = r2;
        nx.rd = r;
        nx.imm = '0;
        nx.use_imm = 1'b0;
      end
      6, 7: begin
        h = {(k == 6) ? 3'b010 : 3'b110, u[5:3], p, u[2], u[6], q, 2'b00};
        nx.fu = (k == 6) ? FU_LOAD : FU_STORE;
        nx.op = (k == 6) ? LW : SW;
        nx.rs1 = {2'b01, p};
        if (k == 6) nx.rd = {2'b01, q};
        else nx.rs2 = {2'b01, q};
        nx.imm = 32'(u);
      end
      8: begin
        h = {3'b101, j[11], j[4], j[9:8], j[10], j[6], j[7], j[3:1], j[5], 2'b01};
        nx.fu = FU_CTRL;
        nx.op = JAL;
        nx.imm = sext(32'(j), 12);
        nx.use_pc = 1'b1;
      end
      default: begin
        h = {2'b11, t, b[8], b[4:3], p, b[7:6], b[2:1], b[5], 2'b01};
        nx.fu = FU_CTRL;
        nx.op = t ? BNE : BEQ;
        nx.rs1 = {2'b01, p};
        nx.imm = sext(32'(b), 9);
        nx.use_imm = 1'b0;
      end
    endcase
    word = {16'(rbits(16)), h};
    send(1'b0);
  endtask

  task automatic gen_exception();
    int k;
    logic fault;
    k = int'(rbits(3)) % 7;
    fault = 1'b0;
    case (k)
      0: word = {25'(rbits(25)), 7'b0001111};
      1: word = {25'(rbits(25)), 7'b1110011};
      2: word = {7'b0000001, 18'(rbits(18)), OPCODE_OP};
      3: word = {17'(rbits(17)), 3'b011, 5'(rbits(5)), OPCODE_LOAD};
      4: word = {16'(rbits(16)), 3'b000, 11'(rbits(11)), 2'b10};
      5: word = '0;
      default: begin
        word = {30'(rbits(30)), 2'b11};
        fault = 1'b1;
      end
    endcase
    nx = blank(pc, word[1:0] != 2'b11);
    nx.ex.valid = 1'b1;
    nx.ex.cause = fault ? CAUSE_INSTR_ACCESS_FAULT : CAUSE_ILLEGAL_INSTR;
    nx.ex.tval = fault ? pc : word;
    send(fault);
  endtask

  task automatic close_test(input string name, input int errs_before);
    while (exp_q.size() != 0 || issue_valid_o) @(negedge clk_i);
    test_num++;
    $display("Test %0d %s finished with %0d errors", test_num, name, errors - errs_before);
  endtask

  // --------------------------------------------------
  // Issue side and expected-queue tracking
  // --------------------------------------------------
  always @(negedge clk_i) begin
    ack_lfsr = lfsr_next(ack_lfsr);
    issue_ack_i = !ack_hold && issue_valid_o && (!ack_rand || ack_lfsr[0]);
  end

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (issue_valid_o && issue_ack_i && exp_q.size() != 0) void'(exp_q.pop_front());
      if (fetch_valid_i && fetch_ready_o) begin
        accept_cnt++;
        if (!flush_i) begin
          exp_q.push_back('{e: nx, w: fetch_instr_i,
                            c: !nx.ex.valid && (nx.op inside {[BEQ:JALR]})});
        end
      end
      // Everything held or accepted at a flush is dropped
      if (flush_i) exp_q.delete();
      exp_any = exp_q.size() != 0;
      exp_head = exp_any ? exp_q[0] : '0;
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  a_issue_matches: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (issue_valid_o && issue_ack_i) |-> (exp_any && issue_entry_o == exp_head.e &&
      issue_orig_instr_o == exp_head.w && issue_is_ctrl_flow_o == exp_head.c))
    else begin
      errors++;
      $display("Mismatch at %0t: issued entry or word differs from the expected head", $time);
    end

  a_ready_rule: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_ready_o == (fetch_valid_i && (!issue_valid_o || issue_ack_i)))
    else begin
      errors++;
      $display("Mismatch at %0t: fetch_ready_o breaks its rule", $time);
    end

  a_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (fetch_valid_i && fetch_ready_o && !issue_valid_o && !flush_i) |=> issue_valid_o)
    else begin
      errors++;
      $display("Error at %0t: an accepted word did not appear one cycle later", $time);
    end

  a_held_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (issue_valid_o && !issue_ack_i && !flush_i) |=>
      (issue_valid_o && $stable(issue_entry_o) && $stable(issue_orig_instr_o)))
    else begin
      errors++;
      $display("Error at %0t: an entry waiting for ack changed or vanished", $time);
    end

  a_flush_empties: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> !issue_valid_o)
    else begin
      errors++;
      $display("Error at %0t: issue stayed valid after a flush", $time);
    end

  // Watchdog sized from the number of tests
  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * 20);
    $display("Watchdog expired before the tests completed");
    $display("TEST FAIL");
    $finish;
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    int e0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    if (issue_valid_o || fetch_ready_o) begin
      reset_bad = 1'b1;
      $display("Error: issue valid or fetch ready high after reset");
    end

    e0 = errors;
    repeat (40) gen_alu();
    close_test("alu", e0);

    e0 = errors;
    repeat (40) gen_other();
    close_test("mem_ctrl_upper", e0);

    e0 = errors;
    repeat (40) gen_compressed();
    close_test("compressed", e0);

    e0 = errors;
    repeat (24) gen_exception();
    close_test("exceptions", e0);

    e0 = errors;
    ack_rand = 1'b1;
    rand_gap = 1'b1;
    for (int i = 0; i < 60; i++) begin
      case (i % 4)
        0: gen_alu();
        1: gen_other();
        2: gen_compressed();
        default: gen_exception();
      endcase
    end
    close_test("random_handshake", e0);

    // Flush a held entry, then a word accepted in the flush cycle
    e0 = errors;
    ack_rand = 1'b0;
    rand_gap = 1'b0;
    ack_hold = 1'b1;
    gen_alu();
    flush_i = 1'b1;
    @(negedge clk_i);
    // Register is empty now, so this word is taken while flush is still high
    nx = blank(pc, 1'b0);
    word = {25'(rbits(25)), OPCODE_OP};
    fetch_valid_i = 1'b1;
    fetch_instr_i = word;
    fetch_pc_i = pc;
    @(negedge clk_i);
    fetch_valid_i = 1'b0;
    flush_i = 1'b0;
    ack_hold = 1'b0;
    repeat (4) gen_other();
    close_test("flush", e0);

    $display("Tests run: %0d, assertion failures: %0d, reset fault: %0d",
             test_num, errors, reset_bad);
    if (errors == 0 && !reset_bad) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== hdl/decode_pkg.sv ====
/*
  Decoded-instruction types passed from the decoder through the ID/issue
  register to the issue side: functional unit, operation, exception and
  the complete scoreboard entry.
*/
package decode_pkg;

  typedef enum logic [2:0] {
    FU_NONE,
    FU_ALU,
    FU_LOAD,
    FU_STORE,
    FU_CTRL
  } fu_t;

  typedef enum logic [4:0] {
    // ALU
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
    // Memory
    LB, LH, LW, LBU, LHU, SB, SH, SW,
    // Branches and jumps
    BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR,
    // Upper immediates
    LUI, AUIPC
  } op_t;

  typedef struct packed {
    logic        valid;
    logic [3:0]  cause;
    logic [31:0] tval;
  } exception_t;

  typedef struct packed {
    logic [31:0] pc;
    fu_t         fu;
    op_t         op;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;           // sign-extended
    logic        use_imm;
    logic        use_pc;
    logic        is_compressed;
    exception_t  ex;
  } scoreboard_entry_t;

endpackage

// ==== hdl/id_if.sv ====
/*
  Handshake bundles around the decode stage. fetch_if is valid/ready,
  a word moves on an edge with both high. issue_if is valid/ack, one ack
  pulse consumes one entry.
*/
interface fetch_if ();
  logic        valid;
  logic        ready;
  logic [31:0] instr;
  logic [31:0] pc;
  logic        fault;

  modport fetch (output valid, output instr, output pc, output fault, input ready);
  modport decode (input valid, input instr, input pc, input fault, output ready);
endinterface

interface issue_if import decode_pkg::*; ();
  logic              valid;
  logic              ack;
  scoreboard_entry_t entry;
  logic [31:0]       orig_instr;
  logic              is_ctrl_flow;

  modport decode (
    output valid,
    output entry,
    output orig_instr,
    output is_ctrl_flow,
    input  ack
  );
  modport issue (
    input  valid,
    input  entry,
    input  orig_instr,
    input  is_ctrl_flow,
    output ack
  );
endinterface

// ==== hdl/id_stage.sv ====
/*
  Decode stage. Expands and decodes the fetched word in the same cycle and
  holds the result in the ID/issue register until issue acks it.
*/
module id_stage
  import decode_pkg::*;
#(
  parameter bit RVC_EN = 1'b1
) (
  input logic     clk_i,
  input logic     rst_ni,
  input logic     flush_i,
  fetch_if.decode fetch,
  issue_if.decode issue
);
  logic [31:0]       instr_exp;
  logic              is_compressed;
  logic              illegal_c;
  scoreboard_entry_t entry_d;
  logic              ctrl_flow_d;
  logic              transfer;
  logic              valid_q;
  scoreboard_entry_t entry_q;
  logic [31:0]       orig_instr_q;
  logic              ctrl_flow_q;

  if (RVC_EN) begin : gen_rvc
    rvc_expander u_rvc_expander (
      .instr_i        (fetch.instr),
      .instr_o        (instr_exp),
      .is_compressed_o(is_compressed),
      .illegal_o      (illegal_c)
    );
  end else begin : gen_no_rvc
    assign instr_exp = fetch.instr;
    assign is_compressed = 1'b0;
    assign illegal_c = 1'b0;
  end

  instr_decoder u_instr_decoder (
    .instr_i        (instr_exp),
    .pc_i           (fetch.pc),
    .is_compressed_i(is_compressed),
    .illegal_i      (illegal_c),
    .fault_i        (fetch.fault),
    .entry_o        (entry_d),
    .is_ctrl_flow_o (ctrl_flow_d)
  );

  // --------------------------------------------------
  // ID/issue register
  // --------------------------------------------------
  // Space exists when empty or when issue takes the held entry this cycle
  assign fetch.ready = fetch.valid && (!valid_q || issue.ack);
  assign transfer = fetch.valid && fetch.ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (transfer) begin
      valid_q <= 1'b1;
    end else if (issue.ack) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (transfer) begin
      entry_q <= entry_d;
      orig_instr_q <= fetch.instr;
      ctrl_flow_q <= ctrl_flow_d;
    end
  end

  assign issue.valid = valid_q;
  assign issue.entry = entry_q;
  assign issue.orig_instr = orig_instr_q;
  assign issue.is_ctrl_flow = ctrl_flow_q;

  // Issue may only ack an entry that is actually held
  a_ack_needs_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni) issue.ack |-> issue.valid);

  a_held_entry_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (issue.valid && !issue.ack && !flush_i) |=> (issue.valid && $stable(issue.entry)));

endmodule

// ==== hdl/id_top.sv ====
/*
  Top level of the decode stage. Maps the plain fetch and issue ports onto
  the two handshake interfaces around id_stage.
*/
module id_top
  import decode_pkg::*;
#(
  parameter bit RVC_EN = 1'b1
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              flush_i,
  input  logic              fetch_valid_i,
  output logic              fetch_ready_o,
  input  logic [31:0]       fetch_instr_i,
  input  logic [31:0]       fetch_pc_i,
  input  logic              fetch_fault_i,
  output logic              issue_valid_o,
  input  logic              issue_ack_i,
  output scoreboard_entry_t issue_entry_o,
  output logic [31:0]       issue_orig_instr_o,
  output logic              issue_is_ctrl_flow_o
);
  fetch_if u_fetch_if ();
  issue_if u_issue_if ();

  assign u_fetch_if.valid = fetch_valid_i;
  assign u_fetch_if.instr = fetch_instr_i;
  assign u_fetch_if.pc = fetch_pc_i;
  assign u_fetch_if.fault = fetch_fault_i;
  assign fetch_ready_o = u_fetch_if.ready;

  assign u_issue_if.ack = issue_ack_i;
  assign issue_valid_o = u_issue_if.valid;
  assign issue_entry_o = u_issue_if.entry;
  assign issue_orig_instr_o = u_issue_if.orig_instr;
  assign issue_is_ctrl_flow_o = u_issue_if.is_ctrl_flow;

  id_stage #(
    .RVC_EN(RVC_EN)
  ) u_id_stage (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .flush_i(flush_i),
    .fetch  (u_fetch_if.decode),
    .issue  (u_issue_if.decode)
  );

endmodule

// ==== hdl/instr_decoder.sv ====
/*
  Combinational RV32I decoder. Turns one 32-bit word into a scoreboard
  entry. Fetch faults and illegal words give an entry with no unit.
*/
module instr_decoder
  import riscv_pkg::*;
  import decode_pkg::*;
(
  input  instr_t            instr_i,
  input  logic [31:0]       pc_i,
  input  logic              is_compressed_i,
  input  logic              illegal_i,
  input  logic              fault_i,
  output scoreboard_entry_t entry_o,
  output logic              is_ctrl_flow_o
);
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  logic [31:0]       imm_i;
  logic [31:0]       imm_s;
  logic [31:0]       imm_b;
  logic [31:0]       imm_u;
  logic [31:0]       imm_j;
  logic              illegal;
  scoreboard_entry_t dec;
  exception_t        ex;

  function automatic op_t alu_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  alu_op = alt ? SUB : ADD;
      3'b001:  alu_op = SLL;
      3'b010:  alu_op = SLT;
      3'b011:  alu_op = SLTU;
      3'b100:  alu_op = XOR;
      3'b101:  alu_op = alt ? SRA : SRL;
      3'b110:  alu_op = OR;
      default: alu_op = AND;
    endcase
  endfunction

  assign funct3 = instr_i.rtype.funct3;
  assign funct7 = instr_i.rtype.funct7;

  // --------------------------------------------------
  // Format immediates
  // --------------------------------------------------
  assign imm_i = {{20{instr_i.itype.imm[11]}}, instr_i.itype.imm};
  assign imm_s = {{20{instr_i.stype.imm_hi[6]}}, instr_i.stype.imm_hi, instr_i.stype.imm_lo};
  assign imm_b = {{20{instr_i.btype.imm12}}, instr_i.btype.imm11, instr_i.btype.imm10_5,
                  instr_i.btype.imm4_1, 1'b0};
  assign imm_u = {instr_i.utype.imm, 12'b0};
  assign imm_j = {{12{instr_i.jtype.imm20}}, instr_i.jtype.imm19_12, instr_i.jtype.imm11,
                  instr_i.jtype.imm10_1, 1'b0};

  always_comb begin
    dec = '0;
    dec.pc = pc_i;
    dec.is_compressed = is_compressed_i;
    illegal = 1'b0;
    case (instr_i.rtype.opcode)
      OPCODE_OP: begin
        dec.fu = FU_ALU;
        dec.op = alu_op(funct3, funct7 == F7_ALT);
        dec.rs1 = instr_i.rtype.rs1;
        dec.rs2 = instr_i.rtype.rs2;
        dec.rd = instr_i.rtype.rd;
        // Only SUB and SRA have an alternate encoding
        illegal = !(funct7 == F7_BASE ||
                    (funct7 == F7_ALT && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA)));
      end
      OPCODE_OPIMM: begin
        dec.fu = FU_ALU;
        dec.op = alu_op(funct3, funct3 == F3_SRL_SRA && funct7 == F7_ALT);
        dec.rs1 = instr_i.itype.rs1;
        dec.rd = instr_i.itype.rd;
        dec.imm = imm_i;
        dec.use_imm = 1'b1;
        if (funct3 == F3_SLL) begin
          illegal = funct7 != F7_BASE;
        end else if (funct3 == F3_SRL_SRA) begin
          illegal = funct7 != F7_BASE && funct7 != F7_ALT;
        end
      end
      OPCODE_LOAD: begin
        dec.fu = FU_LOAD;
        dec.rs1 = instr_i.itype.rs1;
        dec.rd = instr_i.itype.rd;
        dec.imm = imm_i;
        dec.use_imm = 1'b1;
        case (funct3)
          3'b000:  dec.op = LB;
          3'b001:  dec.op = LH;
          3'b010:  dec.op = LW;
          3'b100:  dec.op = LBU;
          3'b101:  dec.op = LHU;
          default: illegal = 1'b1;
        endcase
      end
      OPCODE_STORE: begin
        dec.fu = FU_STORE;
        dec.rs1 = instr_i.stype.rs1;
        dec.rs2 = instr_i.stype.rs2;
        dec.imm = imm_s;
        dec.use_imm = 1'b1;
        case (funct3)
          3'b000:  dec.op = SB;
          3'b001:  dec.op = SH;
          3'b010:  dec.op = SW;
          default: illegal = 1'b1;
        endcase
      end
      OPCODE_BRANCH: begin
        dec.fu = FU_CTRL;
        dec.rs1 = instr_i.btype.rs1;
        dec.rs2 = instr_i.btype.rs2;
        dec.imm = imm_b;
        case (funct3)
          3'b000:  dec.op = BEQ;
          3'b001:  dec.op = BNE;
          3'b100:  dec.op = BLT;
          3'b101:  dec.op = BGE;
          3'b110:  dec.op = BLTU;
          3'b111:  dec.op = BGEU;
          default: illegal = 1'b1;
        endcase
      end
      OPCODE_JAL: begin
        dec.fu = FU_CTRL;
        dec.op = JAL;
        dec.rd = instr_i.jtype.rd;
        dec.imm = imm_j;
        dec.use_imm = 1'b1;
        dec.use_pc = 1'b1;
      end
      OPCODE_JALR: begin
        dec.fu = FU_CTRL;
        dec.op = JALR;
        dec.rs1 = instr_i.itype.rs1;
        dec.rd = instr_i.itype.rd;
        dec.imm = imm_i;
        dec.use_imm = 1'b1;
        illegal = funct3 != 3'b000;
      end
      OPCODE_LUI, OPCODE_AUIPC: begin
        dec.fu = FU_ALU;
        dec.op = (instr_i.utype.opcode == OPCODE_LUI) ? LUI : AUIPC;
        dec.rd = instr_i.utype.rd;
        dec.imm = imm_u;
        dec.use_imm = 1'b1;
        dec.use_pc = instr_i.utype.opcode == OPCODE_AUIPC;
      end
      // FENCE and SYSTEM land here as well
      default: illegal = 1'b1;
    endcase
  end

  // --------------------------------------------------
  // Exceptions, a fetch fault wins over an illegal word
  // --------------------------------------------------
  always_comb begin
    ex = '0;
    if (fault_i) begin
      ex = '{valid: 1'b1, cause: CAUSE_INSTR_ACCESS_FAULT, tval: pc_i};
    end else if (illegal || illegal_i) begin
      ex = '{valid: 1'b1, cause: CAUSE_ILLEGAL_INSTR, tval: instr_i};
    end
    entry_o = dec;
    if (ex.valid) begin
      entry_o = '0;
      entry_o.pc = pc_i;
      entry_o.is_compressed = is_compressed_i;
    end
    entry_o.ex = ex;
  end

  assign is_ctrl_flow_o = entry_o.fu == FU_CTRL;

  // Control-flow entries carry a branch or jump operation
  always_comb begin : a_ctrl_flow_op
    assert (!is_ctrl_flow_o || entry_o.op inside {[BEQ:JALR]});
  end

endmodule

// ==== hdl/riscv_pkg.sv ====
/*
  RV32 encodings used by the decode stage: major opcodes, function codes,
  exception causes and a union that reads one word in every base format.
*/
package riscv_pkg;

  // --------------------------------------------------
  // Major opcodes
  // --------------------------------------------------
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
  localparam logic [6:0] OPCODE_STORE  = 7'b0100011;
  localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
  localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
  localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
  localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
  localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;

  // Function codes that select alternate ALU operations
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [6:0] F7_BASE    = 7'b0000000;
  localparam logic [6:0] F7_ALT     = 7'b0100000;

  // Exception causes
  localparam logic [3:0] CAUSE_INSTR_ACCESS_FAULT = 4'd1;
  localparam logic [3:0] CAUSE_ILLEGAL_INSTR      = 4'd2;

  // --------------------------------------------------
  // Instruction formats
  // --------------------------------------------------
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } rtype;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } itype;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } stype;
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } btype;
    struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } utype;
    struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } jtype;
  } instr_t;

endpackage

// ==== hdl/rvc_expander.sv ====
/*
  Combinational RVC expander. Rebuilds the 32-bit form of C.ADDI, C.NOP,
  C.LI, C.LUI, C.MV, C.ADD, C.LW, C.SW, C.J, C.BEQZ and C.BNEZ. Any other
  compressed word is flagged illegal and passed on unchanged.
*/
module rvc_expander
  import riscv_pkg::*;
(
  input  logic [31:0] instr_i,
  output logic [31:0] instr_o,
  output logic        is_compressed_o,
  output logic        illegal_o
);
  logic [2:0] funct3;
  logic [4:0] rp_lo;
  logic [4:0] rp_hi;
  instr_t     exp;

  assign funct3 = instr_i[15:13];
  // Three-bit register fields address x8 to x15
  assign rp_lo = {2'b01, instr_i[4:2]};
  assign rp_hi = {2'b01, instr_i[9:7]};
  assign instr_o = exp;

  always_comb begin
    exp = instr_i;
    is_compressed_o = 1'b1;
    illegal_o = 1'b0;
    case (instr_i[1:0])
      // Quadrant 0, the zero halfword falls into the default
      2'b00: begin
        case (funct3)
          3'b010: exp = {5'b0, instr_i[5], instr_i[12:10], instr_i[6], 2'b00,
                         rp_hi, 3'b010, rp_lo, OPCODE_LOAD};
          3'b110: exp = {5'b0, instr_i[5], instr_i[12], rp_lo, rp_hi, 3'b010,
                         instr_i[11:10], instr_i[6], 2'b00, OPCODE_STORE};
          default: illegal_o = 1'b1;
        endcase
      end
      2'b01: begin
        case (funct3)
          // C.ADDI and C.NOP add to rd, C.LI adds to x0
          3'b000, 3'b010: begin
            exp.itype.imm = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2]};
            exp.itype.rs1 = (funct3 == 3'b000) ? instr_i[11:7] : 5'd0;
            exp.itype.funct3 = F3_ADD_SUB;
            exp.itype.rd = instr_i[11:7];
            exp.itype.opcode = OPCODE_OPIMM;
          end
          3'b011: begin
            exp = {{15{instr_i[12]}}, instr_i[6:2], instr_i[11:7], OPCODE_LUI};
            // rd of x2 is C.ADDI16SP, not supported
            illegal_o = (instr_i[11:7] == 5'd2) || ({instr_i[12], instr_i[6:2]} == 6'd0);
          end
          3'b101: exp = {instr_i[12], instr_i[8], instr_i[10:9], instr_i[6], instr_i[7],
                         instr_i[2], instr_i[11], instr_i[5:3], instr_i[12],
                         {8{instr_i[12]}}, 5'd0, OPCODE_JAL};
          // C.BEQZ and C.BNEZ differ only in funct3 bit 0
          3'b110, 3'b111: exp = {{4{instr_i[12]}}, instr_i[6:5], instr_i[2], 5'd0, rp_hi,
                                 2'b00, instr_i[13], instr_i[11:10], instr_i[4:3],
                                 instr_i[12], OPCODE_BRANCH};
          default: illegal_o = 1'b1;
        endcase
      end
      2'b10: begin
        // C.MV and C.ADD need a nonzero rs2, otherwise C.JR or C.JALR
        if (funct3 == 3'b100 && instr_i[6:2] != 5'd0) begin
          exp.rtype.funct7 = F7_BASE;
          exp.rtype.rs2 = instr_i[6:2];
          exp.rtype.rs1 = instr_i[12] ? instr_i[11:7] : 5'd0;
          exp.rtype.funct3 = F3_ADD_SUB;
          exp.rtype.rd = instr_i[11:7];
          exp.rtype.opcode = OPCODE_OP;
        end else begin
          illegal_o = 1'b1;
        end
      end
      default: is_compressed_o = 1'b0;
    endcase
    // Illegal words keep their raw form so the trap value is the fetched word
    if (illegal_o) begin
      exp = instr_i;
    end
  end

  // A legal expansion always ends in a full-length opcode
  always_comb begin : a_expanded_full_length
    assert (illegal_o || instr_o[1:0] == 2'b11);
  end

endmodule

// ==== id_top.f ====
hdl/riscv_pkg.sv
hdl/decode_pkg.sv
hdl/id_if.sv
hdl/rvc_expander.sv
hdl/instr_decoder.sv
hdl/id_stage.sv
hdl/id_top.sv
dv/id_top_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f id_top.f --top-module id_top_tb -o id_top_sim \
  && ./obj_dir/id_top_sim > sim.log 2>&1
cat sim.log 2>/dev/null

grep -qx "TEST PASS" sim.log && echo "Simulation passed" && exit 0 \
  || { echo "Simulation failed"; exit 1; }
